// ==== design/exec_pkg.sv ====
package exec_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int opcode_w   = 17;  // {major, funct3, funct7}
    localparam int strb_w     = 4;

    localparam logic [strb_w-1:0] strb_byte = 4'b0001;
    localparam logic [strb_w-1:0] strb_half = 4'b0011;
    localparam logic [strb_w-1:0] strb_word = 4'b1111;

    typedef enum logic [5:0] {
        op_nop,
        // register forms
        op_add, op_sub, op_and, op_or, op_xor,
        op_sll, op_srl, op_sra, op_slt, op_sltu,
        // immediate forms
        op_addi, op_andi, op_ori, op_xori,
        op_slli, op_srli, op_srai, op_slti, op_sltiu,
        op_lui, op_auipc, op_jal, op_jalr,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_lb, op_lbu, op_lh, op_lhu, op_lw,
        op_sb, op_sh, op_sw
    } exec_op_e;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [opcode_w-1:0]   opcode;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       rs1_data;
        logic [xlen-1:0]       rs2_data;
        logic [xlen-1:0]       imm;
    } exec_in_t;

    typedef struct packed {
        exec_op_e        op;
        logic [xlen-1:0] imm_i;  // sign extended 12 bit
        logic [xlen-1:0] imm_b;  // branch offset, bit 0 zero
        logic [xlen-1:0] imm_u;  // upper 20 bits in place
    } dec_t;

    typedef struct packed {
        logic                  en;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
    } reg_wr_t;

    typedef struct packed {
        logic                  en;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       addr;
        logic [strb_w-1:0]     strb;
        logic                  signed_ld;
    } mem_rd_t;

    typedef struct packed {
        logic              en;
        logic [xlen-1:0]   addr;
        logic [strb_w-1:0] strb;
        logic [xlen-1:0]   data;
    } mem_wr_t;

    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } jump_t;

endpackage

// ==== design/exec_input_reg.sv ====
module exec_input_reg (
    input  logic               CLK,
    input  logic               reset,
    input  logic               flush,
    input  logic               stall,
    input  logic               mem_wait,
    input  exec_pkg::exec_in_t instr,
    output exec_pkg::exec_in_t cur
);

    // priority: reset/flush, mem_wait, stall, load
    always_ff @(posedge CLK) begin
        if (reset || flush) begin
            cur <= '0;
        end
        else if (mem_wait) begin
            cur <= cur;  // memory stage busy
        end
        else if (stall) begin
            cur <= '0;  // bubble
        end
        else begin
            cur <= instr;
        end
    end

    // a flushed slot must never reach the units as a live instruction
    flush_clears_cur: assert property (
        @(posedge CLK) disable iff (reset)
        flush |=> (cur == '0)
    ) else $error("exec_input_reg: cur not cleared after flush");

endmodule

// ==== design/exec_decode.sv ====
module exec_decode (
    input  logic [exec_pkg::opcode_w-1:0] opcode,
    input  logic [exec_pkg::xlen-1:0]     imm,
    output exec_pkg::dec_t                dec
);

    exec_pkg::exec_op_e op;

    // opcode layout: major[16:10] funct3[9:7] funct7[6:0]
    always_comb begin
        casez (opcode)
            17'b0110011_000_0000000: op = exec_pkg::op_add;
            17'b0110011_000_0100000: op = exec_pkg::op_sub;
            17'b0110011_001_0000000: op = exec_pkg::op_sll;
            17'b0110011_010_0000000: op = exec_pkg::op_slt;
            17'b0110011_011_0000000: op = exec_pkg::op_sltu;
            17'b0110011_100_0000000: op = exec_pkg::op_xor;
            17'b0110011_101_0000000: op = exec_pkg::op_srl;
            17'b0110011_101_0100000: op = exec_pkg::op_sra;
            17'b0110011_110_0000000: op = exec_pkg::op_or;
            17'b0110011_111_0000000: op = exec_pkg::op_and;
            17'b0010011_000_???????: op = exec_pkg::op_addi;
            17'b0010011_010_???????: op = exec_pkg::op_slti;
            17'b0010011_011_???????: op = exec_pkg::op_sltiu;
            17'b0010011_100_???????: op = exec_pkg::op_xori;
            17'b0010011_110_???????: op = exec_pkg::op_ori;
            17'b0010011_111_???????: op = exec_pkg::op_andi;
            17'b0010011_001_0000000: op = exec_pkg::op_slli;  // shifts check funct7
            17'b0010011_101_0000000: op = exec_pkg::op_srli;
            17'b0010011_101_0100000: op = exec_pkg::op_srai;
            17'b0110111_???_???????: op = exec_pkg::op_lui;
            17'b0010111_???_???????: op = exec_pkg::op_auipc;
            17'b1101111_???_???????: op = exec_pkg::op_jal;
            17'b1100111_000_???????: op = exec_pkg::op_jalr;
            17'b1100011_000_???????: op = exec_pkg::op_beq;
            17'b1100011_001_???????: op = exec_pkg::op_bne;
            17'b1100011_100_???????: op = exec_pkg::op_blt;
            17'b1100011_101_???????: op = exec_pkg::op_bge;
            17'b1100011_110_???????: op = exec_pkg::op_bltu;
            17'b1100011_111_???????: op = exec_pkg::op_bgeu;
            17'b0000011_000_???????: op = exec_pkg::op_lb;
            17'b0000011_001_???????: op = exec_pkg::op_lh;
            17'b0000011_010_???????: op = exec_pkg::op_lw;
            17'b0000011_100_???????: op = exec_pkg::op_lbu;
            17'b0000011_101_???????: op = exec_pkg::op_lhu;
            17'b0100011_000_???????: op = exec_pkg::op_sb;
            17'b0100011_001_???????: op = exec_pkg::op_sh;
            17'b0100011_010_???????: op = exec_pkg::op_sw;
            default:                 op = exec_pkg::op_nop;  // incl. all zero
        endcase
    end

    // immediates arrive with their bits in instruction position
    always_comb begin
        dec.op    = op;
        dec.imm_i = {{(exec_pkg::xlen - 12){imm[11]}}, imm[11:0]};
        dec.imm_b = {{(exec_pkg::xlen - 13){imm[12]}}, imm[12:1], 1'b0};
        dec.imm_u = {imm[31:12], 12'b0};
    end

endmodule

// ==== design/int_alu.sv ====
module int_alu (
    input  exec_pkg::exec_in_t cur,
    input  exec_pkg::dec_t     dec,
    output exec_pkg::reg_wr_t  reg_wr
);

    logic                      imm_form;
    logic [exec_pkg::xlen-1:0] src_b;
    logic [4:0]                shamt;
    logic                      wr_en;
    logic [exec_pkg::xlen-1:0] wr_data;

    assign imm_form = dec.op inside {exec_pkg::op_addi, exec_pkg::op_andi, exec_pkg::op_ori,
                                     exec_pkg::op_xori, exec_pkg::op_slli, exec_pkg::op_srli,
                                     exec_pkg::op_srai, exec_pkg::op_slti, exec_pkg::op_sltiu};
    assign src_b = imm_form ? dec.imm_i : cur.rs2_data;
    assign shamt = src_b[4:0];

    always_comb begin
        wr_en   = 1'b1;
        wr_data = '0;
        case (dec.op)
            exec_pkg::op_add, exec_pkg::op_addi: wr_data = cur.rs1_data + src_b;
            exec_pkg::op_sub:                    wr_data = cur.rs1_data - src_b;
            exec_pkg::op_and, exec_pkg::op_andi: wr_data = cur.rs1_data & src_b;
            exec_pkg::op_or, exec_pkg::op_ori:   wr_data = cur.rs1_data | src_b;
            exec_pkg::op_xor, exec_pkg::op_xori: wr_data = cur.rs1_data ^ src_b;
            exec_pkg::op_sll, exec_pkg::op_slli: wr_data = cur.rs1_data << shamt;
            exec_pkg::op_srl, exec_pkg::op_srli: wr_data = cur.rs1_data >> shamt;
            exec_pkg::op_sra, exec_pkg::op_srai: begin
                wr_data = $unsigned($signed(cur.rs1_data) >>> shamt);
            end
            exec_pkg::op_slt, exec_pkg::op_slti: begin
                wr_data[0] = $signed(cur.rs1_data) < $signed(src_b);
            end
            exec_pkg::op_sltu, exec_pkg::op_sltiu: begin
                wr_data[0] = cur.rs1_data < src_b;
            end
            exec_pkg::op_lui:   wr_data = dec.imm_u;
            exec_pkg::op_auipc: wr_data = cur.pc + dec.imm_u;
            exec_pkg::op_jal, exec_pkg::op_jalr: begin
                wr_data = cur.pc + exec_pkg::xlen'(4);  // link address
            end
            default: wr_en = 1'b0;  // loads write back from the memory stage
        endcase
    end

    assign reg_wr.en   = wr_en;
    assign reg_wr.rd   = wr_en ? cur.rd : '0;
    assign reg_wr.data = wr_data;

    // decoder and alu must agree that memory ops never use this port
    always_comb begin
        assert final (!(reg_wr.en && dec.op inside {
                exec_pkg::op_lb, exec_pkg::op_lbu, exec_pkg::op_lh, exec_pkg::op_lhu,
                exec_pkg::op_lw, exec_pkg::op_sb, exec_pkg::op_sh, exec_pkg::op_sw}))
            else $error("int_alu: write-back raised for a load or store");
    end

endmodule

// ==== design/addr_unit.sv ====
module addr_unit (
    input  exec_pkg::exec_in_t cur,
    input  exec_pkg::dec_t     dec,
    output exec_pkg::mem_rd_t  mem_rd,
    output exec_pkg::mem_wr_t  mem_wr,
    output exec_pkg::jump_t    jump
);

    logic [exec_pkg::xlen-1:0] ea;         // rs1 + imm_i
    logic [exec_pkg::xlen-1:0] br_target;  // pc + imm_b
    logic                      eq;
    logic                      lt_s;
    logic                      lt_u;
    logic                      is_branch;

    assign ea        = cur.rs1_data + dec.imm_i;
    assign br_target = cur.pc + dec.imm_b;
    assign eq        = cur.rs1_data == cur.rs2_data;
    assign lt_s      = $signed(cur.rs1_data) < $signed(cur.rs2_data);
    assign lt_u      = cur.rs1_data < cur.rs2_data;
    assign is_branch = dec.op inside {exec_pkg::op_beq, exec_pkg::op_bne, exec_pkg::op_blt,
                                      exec_pkg::op_bge, exec_pkg::op_bltu, exec_pkg::op_bgeu};

    always_comb begin
        mem_rd = '0;
        case (dec.op)
            exec_pkg::op_lb: begin
                mem_rd.strb      = exec_pkg::strb_byte;
                mem_rd.signed_ld = 1'b1;
            end
            exec_pkg::op_lh: begin
                mem_rd.strb      = exec_pkg::strb_half;
                mem_rd.signed_ld = 1'b1;
            end
            exec_pkg::op_lbu: mem_rd.strb = exec_pkg::strb_byte;
            exec_pkg::op_lhu: mem_rd.strb = exec_pkg::strb_half;
            exec_pkg::op_lw:  mem_rd.strb = exec_pkg::strb_word;
            default:          mem_rd.strb = '0;
        endcase
        if (mem_rd.strb != '0) begin  // any load
            mem_rd.en   = 1'b1;
            mem_rd.rd   = cur.rd;
            mem_rd.addr = ea;
        end
    end

    always_comb begin
        mem_wr = '0;
        case (dec.op)
            exec_pkg::op_sb: mem_wr.strb = exec_pkg::strb_byte;
            exec_pkg::op_sh: mem_wr.strb = exec_pkg::strb_half;
            exec_pkg::op_sw: mem_wr.strb = exec_pkg::strb_word;
            default:         mem_wr.strb = '0;
        endcase
        if (mem_wr.strb != '0) begin
            mem_wr.en   = 1'b1;
            mem_wr.addr = ea;
            mem_wr.data = cur.rs2_data;  // unaligned lanes left to memory stage
        end
    end

    always_comb begin
        jump = '0;
        case (dec.op)
            exec_pkg::op_beq:  jump.taken = eq;
            exec_pkg::op_bne:  jump.taken = !eq;
            exec_pkg::op_blt:  jump.taken = lt_s;
            exec_pkg::op_bge:  jump.taken = !lt_s;
            exec_pkg::op_bltu: jump.taken = lt_u;
            exec_pkg::op_bgeu: jump.taken = !lt_u;
            exec_pkg::op_jal, exec_pkg::op_jalr: jump.taken = 1'b1;
            default:           jump.taken = 1'b0;
        endcase
        if (is_branch || dec.op == exec_pkg::op_jal)
            jump.target = br_target;
        else if (dec.op == exec_pkg::op_jalr)
            jump.target = {ea[exec_pkg::xlen-1:1], 1'b0};
    end

    // odd targets would mean a misaligned pc came in from fetch
    always_comb begin
        assert final (!(mem_rd.en && mem_wr.en))
            else $error("addr_unit: load and store requested together");
        assert final (!jump.taken || !jump.target[0])
            else $error("addr_unit: taken jump to odd target %h", jump.target);
    end

endmodule

// ==== design/exec_stage.sv ====
module exec_stage (
    input  logic                      CLK,
    input  logic                      reset,
    input  logic                      flush,
    input  logic                      stall,
    input  logic                      mem_wait,
    input  exec_pkg::exec_in_t        instr,
    output logic [exec_pkg::xlen-1:0] pc,
    output exec_pkg::reg_wr_t         reg_wr,
    output exec_pkg::mem_rd_t         mem_rd,
    output exec_pkg::mem_wr_t         mem_wr,
    output exec_pkg::jump_t           jump
);

    exec_pkg::exec_in_t cur;  // instruction in execute
    exec_pkg::dec_t     dec;

    exec_input_reg in_reg0 (
        .CLK      (CLK),
        .reset    (reset),
        .flush    (flush),
        .stall    (stall),
        .mem_wait (mem_wait),
        .instr    (instr),
        .cur      (cur)
    );

    exec_decode decode0 (
        .opcode (cur.opcode),
        .imm    (cur.imm),
        .dec    (dec)
    );

    // write-back side
    int_alu alu0 (
        .cur    (cur),
        .dec    (dec),
        .reg_wr (reg_wr)
    );

    // memory and control flow side
    addr_unit addr0 (
        .cur    (cur),
        .dec    (dec),
        .mem_rd (mem_rd),
        .mem_wr (mem_wr),
        .jump   (jump)
    );

    assign pc = cur.pc;

endmodule

// ==== sim/exec_tests.svh ====
function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return {31'b0, $signed(a) < $signed(b)};
        3'b011:  return {31'b0, a < b};
        3'b100:  return a ^ b;
        3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        3'b110:  return a < b;
        default: return a >= b;
    endcase
endfunction

function automatic exec_pkg::reg_wr_t lui_result(input exec_pkg::exec_in_t in);
    return {1'b1, in.rd, upper_imm(in.imm)};
endfunction

task automatic reset_and_unknown();
    exec_pkg::exec_in_t in;
    expect_idle(32'h0);  // straight out of reset
    in = '0;
    issue(in);
    expect_idle(32'h0);
    in = random_instr();
    in.opcode = 17'(rand_bits(17));
    in.opcode[16:10] = 7'b1111111;  // unused major opcode
    issue(in);
    expect_idle(in.pc);
    in.opcode = {7'b0110011, 3'b000, 7'b1111111};  // bad funct7
    issue(in);
    expect_idle(in.pc);
    in.opcode = {7'b0010011, 3'b001, 7'b0000001};  // slli needs funct7 zero
    issue(in);
    expect_idle(in.pc);
endtask

task automatic alu_case(input logic imm_form, input logic [2:0] f3, input logic alt);
    exec_pkg::exec_in_t in;
    exec_pkg::reg_wr_t  er;
    logic [6:0]         f7;
    logic [31:0]        b;
    in = random_instr();
    f7 = alt ? 7'b0100000 : 7'b0000000;
    if (imm_form && f3 != 3'b001 && f3 != 3'b101) begin
        f7 = 7'(rand_bits(7));  // don't care outside shifts
    end
    in.opcode = {imm_form ? 7'b0010011 : 7'b0110011, f3, f7};
    b = imm_form ? sign_ext12(in.imm) : in.rs2_data;
    er = {1'b1, in.rd, alu_model(f3, alt, in.rs1_data, b)};
    issue(in);
    compare_outputs(in.pc, er, '0, '0, '0);
endtask

task automatic alu_ops();
    for (int r = 0; r < alu_rounds; r++) begin
        for (int k = 0; k < 8; k++) begin
            alu_case(1'b0, 3'(k), 1'b0);
            alu_case(1'b1, 3'(k), 1'b0);
        end
        alu_case(1'b0, 3'b000, 1'b1);  // sub
        alu_case(1'b0, 3'b101, 1'b1);  // sra
        alu_case(1'b1, 3'b101, 1'b1);  // srai
    end
endtask

task automatic upper_and_jumps();
    exec_pkg::exec_in_t in;
    exec_pkg::reg_wr_t  er;
    exec_pkg::jump_t    ej;
    for (int r = 0; r < 4; r++) begin
        in = random_instr();
        in.opcode = {7'b0110111, 10'(rand_bits(10))};
        issue(in);
        compare_outputs(in.pc, lui_result(in), '0, '0, '0);
        in = random_instr();
        in.opcode = {7'b0010111, 10'(rand_bits(10))};
        er = {1'b1, in.rd, in.pc + upper_imm(in.imm)};
        issue(in);
        compare_outputs(in.pc, er, '0, '0, '0);
        in = random_instr();
        in.opcode = {7'b1101111, 10'(rand_bits(10))};
        er = {1'b1, in.rd, in.pc + 32'd4};
        ej = {1'b1, in.pc + branch_offset(in.imm)};
        issue(in);
        compare_outputs(in.pc, er, '0, '0, ej);
        in = random_instr();
        in.opcode = {7'b1100111, 3'b000, 7'(rand_bits(7))};
        er = {1'b1, in.rd, in.pc + 32'd4};
        ej = {1'b1, (in.rs1_data + sign_ext12(in.imm)) & ~32'd1};
        issue(in);
        compare_outputs(in.pc, er, '0, '0, ej);
    end
endtask

task automatic branch_case(input logic [2:0] f3, input logic [31:0] a, input logic [31:0] b);
    exec_pkg::exec_in_t in;
    exec_pkg::jump_t    ej;
    in = random_instr();
    in.opcode = {7'b1100011, f3, 7'(rand_bits(7))};
    in.rs1_data = a;
    in.rs2_data = b;
    ej = {branch_taken(f3, a, b), in.pc + branch_offset(in.imm)};
    issue(in);
    compare_outputs(in.pc, '0, '0, '0, ej);
endtask

task automatic branch_ops();
    logic [31:0] a;
    logic [31:0] b;
    for (int k = 0; k < 8; k++) begin
        if (k == 2 || k == 3) begin
            continue;  // no branch there
        end
        for (int r = 0; r < 4; r++) begin
            a = rand_bits(32);
            b = rand_bits(32);
            if (r % 2 == 1) begin  // signed and unsigned order disagree
                a[31] = 1'b0;
                b[31] = 1'b1;
            end
            if (a == b) begin
                b = ~a;
            end
            branch_case(3'(k), a, a);
            branch_case(3'(k), a, b);
            branch_case(3'(k), b, a);
        end
    end
endtask

task automatic mem_case(input logic store, input logic [2:0] f3);
    exec_pkg::exec_in_t in;
    exec_pkg::mem_rd_t  emr;
    exec_pkg::mem_wr_t  emw;
    logic [31:0]        ea;
    logic [3:0]         strb;
    in = random_instr();
    in.opcode = {store ? 7'b0100011 : 7'b0000011, f3, 7'(rand_bits(7))};
    ea = in.rs1_data + sign_ext12(in.imm);
    case (f3[1:0])
        2'b00:   strb = exec_pkg::strb_byte;
        2'b01:   strb = exec_pkg::strb_half;
        default: strb = exec_pkg::strb_word;
    endcase
    emr = '0;
    emw = '0;
    if (store) begin
        emw = {1'b1, ea, strb, in.rs2_data};
    end
    else begin
        emr = {1'b1, in.rd, ea, strb, f3 == 3'b000 || f3 == 3'b001};
    end
    issue(in);
    compare_outputs(in.pc, '0, emr, emw, '0);
endtask

task automatic loads_and_stores();
    for (int r = 0; r < 3; r++) begin
        mem_case(1'b0, 3'b000);
        mem_case(1'b0, 3'b100);
        mem_case(1'b0, 3'b001);
        mem_case(1'b0, 3'b101);
        mem_case(1'b0, 3'b010);
        mem_case(1'b1, 3'b000);
        mem_case(1'b1, 3'b001);
        mem_case(1'b1, 3'b010);
    end
endtask

task automatic control_levels();
    exec_pkg::exec_in_t a_in;
    exec_pkg::exec_in_t b_in;
    exec_pkg::mem_wr_t  b_wr;
    a_in = random_instr();
    a_in.opcode = {7'b0110111, 10'(rand_bits(10))};  // lui
    b_in = random_instr();
    b_in.opcode = {7'b0100011, 3'b010, 7'(rand_bits(7))};  // sw
    b_wr = {1'b1, b_in.rs1_data + sign_ext12(b_in.imm), exec_pkg::strb_word, b_in.rs2_data};
    issue(a_in);
    compare_outputs(a_in.pc, lui_result(a_in), '0, '0, '0);
    mem_wait = 1'b1;
    issue(b_in);
    compare_outputs(a_in.pc, lui_result(a_in), '0, '0, '0);
    stall = 1'b1;  // mem_wait still holds over stall
    issue(b_in);
    compare_outputs(a_in.pc, lui_result(a_in), '0, '0, '0);
    stall = 1'b0;
    mem_wait = 1'b0;
    issue(b_in);
    compare_outputs(b_in.pc, '0, '0, b_wr, '0);
    stall = 1'b1;
    issue(a_in);
    expect_idle(32'h0);
    stall = 1'b0;
    issue(a_in);
    compare_outputs(a_in.pc, lui_result(a_in), '0, '0, '0);
    flush = 1'b1;
    issue(b_in);
    expect_idle(32'h0);
    mem_wait = 1'b1;  // flush beats mem_wait
    issue(b_in);
    expect_idle(32'h0);
    flush = 1'b0;
    mem_wait = 1'b0;
    issue(b_in);
    compare_outputs(b_in.pc, '0, '0, b_wr, '0);
endtask

// ==== sim/exec_tb.sv ====
module exec_tb;

    localparam int drive_delay  = 10;
    localparam int reset_cycles = 5;
    localparam int alu_rounds   = 20;
    // reset, nop checks, alu, upper/jump, branches, loads/stores, control levels
    localparam int test_cycles  = reset_cycles + 4 + alu_rounds * 19 + 4 * 4
                                  + 6 * 4 * 3 + 3 * 8 + 10;
    localparam int cycle_limit  = 2 * test_cycles;

    logic                      CLK;
    logic                      reset;
    logic                      flush;
    logic                      stall;
    logic                      mem_wait;
    exec_pkg::exec_in_t        instr;
    logic [exec_pkg::xlen-1:0] pc;
    exec_pkg::reg_wr_t         reg_wr;
    exec_pkg::mem_rd_t         mem_rd;
    exec_pkg::mem_wr_t         mem_wr;
    exec_pkg::jump_t           jump;

    logic [31:0] lfsr = 32'hfb50;
    int          cycle_count = 0;

    exec_stage dut0 (
        .CLK      (CLK),
        .reset    (reset),
        .flush    (flush),
        .stall    (stall),
        .mem_wait (mem_wait),
        .instr    (instr),
        .pc       (pc),
        .reg_wr   (reg_wr),
        .mem_rd   (mem_rd),
        .mem_wr   (mem_wr),
        .jump     (jump)
    );

    always #50 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: tests still running after %0d cycles", cycle_count);
            $display("SIMULATION FAILED");
            $fatal(1, "run stopped by cycle limit");
        end
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // taps 32,22,2,1
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] sign_ext12(input logic [31:0] imm);
        return {{20{imm[11]}}, imm[11:0]};
    endfunction

    function automatic logic [31:0] branch_offset(input logic [31:0] imm);
        return {{19{imm[12]}}, imm[12:1], 1'b0};
    endfunction

    function automatic logic [31:0] upper_imm(input logic [31:0] imm);
        return {imm[31:12], 12'b0};
    endfunction

    function automatic exec_pkg::exec_in_t random_instr();
        exec_pkg::exec_in_t in;
        in.pc       = rand_bits(30) << 2;  // fetch only gives aligned pc
        in.opcode   = '0;
        in.rd       = 5'(rand_bits(5));
        in.rs1_data = rand_bits(32);
        in.rs2_data = rand_bits(32);
        in.imm      = rand_bits(32);
        return in;
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error: %s is %h, expected %h", name, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic compare_outputs(input logic [31:0] epc, input exec_pkg::reg_wr_t er,
                                   input exec_pkg::mem_rd_t emr, input exec_pkg::mem_wr_t emw,
                                   input exec_pkg::jump_t ej);
        check("pc", pc, epc);
        check("reg_wr.en", 32'(reg_wr.en), 32'(er.en));
        check("reg_wr.rd", 32'(reg_wr.rd), 32'(er.rd));
        check("reg_wr.data", reg_wr.data, er.data);
        check("mem_rd.en", 32'(mem_rd.en), 32'(emr.en));
        check("mem_rd.rd", 32'(mem_rd.rd), 32'(emr.rd));
        check("mem_rd.addr", mem_rd.addr, emr.addr);
        check("mem_rd.strb", 32'(mem_rd.strb), 32'(emr.strb));
        check("mem_rd.signed_ld", 32'(mem_rd.signed_ld), 32'(emr.signed_ld));
        check("mem_wr.en", 32'(mem_wr.en), 32'(emw.en));
        check("mem_wr.addr", mem_wr.addr, emw.addr);
        check("mem_wr.strb", 32'(mem_wr.strb), 32'(emw.strb));
        check("mem_wr.data", mem_wr.data, emw.data);
        check("jump.taken", 32'(jump.taken), 32'(ej.taken));
        check("jump.target", jump.target, ej.target);
    endtask

    task automatic expect_idle(input logic [31:0] epc);
        compare_outputs(epc, '0, '0, '0, '0);
    endtask

    // present one instruction and let it pass the input register
    task automatic issue(input exec_pkg::exec_in_t in);
        instr = in;
        @(posedge CLK);
        #drive_delay;
    endtask

`include "exec_tests.svh"

    initial begin
        CLK          = 1'b0;
        reset        = 1'b1;
        flush        = 1'b0;
        stall        = 1'b0;
        mem_wait     = 1'b0;
        instr        = random_instr();
        instr.opcode = {7'b0110111, 10'h0};  // live lui waiting at the input during reset
        repeat (reset_cycles) @(posedge CLK);
        #drive_delay;
        reset = 1'b0;
        reset_and_unknown();
        alu_ops();
        upper_and_jumps();
        branch_ops();
        loads_and_stores();
        control_levels();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+sim
design/exec_pkg.sv
design/exec_input_reg.sv
design/exec_decode.sv
design/int_alu.sv
design/addr_unit.sv
design/exec_stage.sv
sim/exec_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= exec_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the verdict comes from the log, not from the exit status of the binary
run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "verdict: fail"; exit 1; \
	elif grep -q "SIMULATION PASSED" $(LOG); then \
		echo "verdict: pass"; \
	else \
		echo "verdict: no result in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
